// File: logic/switch_defines.svh
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

// switch geometry
`define SW_NUM_PORTS     4
`define SW_PAGE_WORDS    8
`define SW_NUM_PAGES     32
`define SW_MAX_PKT_WORDS 32
`define SW_QUEUE_DEPTH   8

// header word fields
`define SW_HDR_LEN_LSB   7
`define SW_HDR_LEN_MSB   15
`define SW_HDR_DEST_MSB  1

`endif

// File: logic/packet_pkg.sv
`default_nettype none

`include "switch_defines.svh"

package packet_pkg;

    // one data word on every port
    typedef logic [15:0] halfword_t;

    typedef logic [`SW_HDR_DEST_MSB:0] port_id_t;

    // length in halfwords, header included
    typedef logic [`SW_HDR_LEN_MSB-`SW_HDR_LEN_LSB:0] pkt_len_t;

endpackage

`default_nettype wire

// File: logic/buffer_pkg.sv
`default_nettype none

`include "switch_defines.svh"

package buffer_pkg;

    typedef logic [$clog2(`SW_NUM_PAGES)-1:0] page_ptr_t;
    typedef logic [$clog2(`SW_PAGE_WORDS)-1:0] word_idx_t;

    // full data SRAM address, page in the upper bits
    typedef logic [$bits(page_ptr_t)+$bits(word_idx_t)-1:0] data_addr_t;

    // number of free pages, 0 up to all of them
    typedef logic [$clog2(`SW_NUM_PAGES):0] page_cnt_t;

    // one queued packet
    typedef struct packed {
        page_ptr_t           first_page;
        packet_pkg::pkt_len_t len;
    } desc_t;

endpackage

`default_nettype wire

// File: logic/ingress_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module ingress_buffer (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wr_sop,
    input  wire logic                  wr_eop,
    input  wire logic                  wr_vld,
    input  wire packet_pkg::halfword_t wr_data,
    output logic                       full,
    output logic                       pkt_avail,
    output packet_pkg::port_id_t       pkt_dest,
    output packet_pkg::pkt_len_t       pkt_len,
    input  wire logic                  take,
    output logic                       word_vld,
    output packet_pkg::halfword_t      word
);
    import packet_pkg::*;

    localparam int idx_w = $clog2(`SW_MAX_PKT_WORDS);

    halfword_t      mem [`SW_MAX_PKT_WORDS];
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] last_idx;
    logic           holding;
    logic           replaying;
    pkt_len_t       hdr_len;

    assign hdr_len  = mem[0][`SW_HDR_LEN_MSB:`SW_HDR_LEN_LSB];
    assign last_idx = idx_w'(pkt_len - 1'b1);

    // sop always lands at slot 0
    always_ff @(posedge clk) begin
        if (wr_vld) begin
            mem[wr_sop ? '0 : wr_idx] <= wr_data;
        end
        if (wr_vld && wr_eop) begin
            pkt_dest <= mem[0][`SW_HDR_DEST_MSB:0];
            pkt_len  <= hdr_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx    <= '0;
            rd_idx    <= '0;
            holding   <= 1'b0;
            replaying <= 1'b0;
        end else begin
            if (wr_vld) begin
                wr_idx <= wr_sop ? idx_w'(1) : wr_idx + 1'b1;
            end
            // held from eop until the last word has been replayed
            if (wr_vld && wr_eop) begin
                holding <= 1'b1;
            end else if (replaying && rd_idx == last_idx) begin
                holding <= 1'b0;
            end
            if (take) begin
                replaying <= 1'b1;
                rd_idx    <= '0;
            end else if (replaying) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == last_idx) begin
                    replaying <= 1'b0;
                end
            end
        end
    end

    assign full      = holding;
    assign pkt_avail = holding;
    assign word_vld  = replaying;
    assign word      = mem[rd_idx];

    // header length must agree with the words actually sent
    a_len_match: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && wr_eop && !wr_sop |-> hdr_len == pkt_len_t'(wr_idx) + 1'b1);

endmodule

`default_nettype wire

// File: logic/page_store.sv
`timescale 1ns/1ps
`default_nettype none

module page_store #(
    parameter type word_t     = logic [15:0],
    parameter int  addr_width = 5
) (
    input  wire logic                  clk,
    input  wire logic                  wr_en,
    input  wire logic [addr_width-1:0] wr_addr,
    input  wire word_t                 wr_data,
    input  wire logic [addr_width-1:0] rd_addr,
    output word_t                      rd_data
);

    word_t mem [2**addr_width];

    // read data registered, one cycle after the address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: logic/free_page_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module free_page_list (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   alloc,
    output buffer_pkg::page_ptr_t       free_head,
    input  wire logic                   release_vld,
    input  wire buffer_pkg::page_ptr_t  release_page,
    output buffer_pkg::page_cnt_t       free_count
);
    import buffer_pkg::*;

    page_ptr_t mem [`SW_NUM_PAGES];
    page_ptr_t rd_ptr;
    page_ptr_t wr_ptr;
    page_cnt_t count;
    logic      refilling;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            refilling <= 1'b1;
        end else begin
            if (refilling) begin
                // every page number once, in order
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_ptr == page_ptr_t'(`SW_NUM_PAGES - 1)) begin
                    refilling <= 1'b0;
                end
            end else begin
                if (alloc) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (release_vld) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            count <= count + page_cnt_t'(refilling || release_vld) - page_cnt_t'(alloc);
        end
    end

    always_ff @(posedge clk) begin
        if (refilling) begin
            mem[wr_ptr] <= wr_ptr;
        end else if (release_vld) begin
            mem[wr_ptr] <= release_page;
        end
    end

    assign free_head  = mem[rd_ptr];
    // nothing to hand out until the refill is done
    assign free_count = refilling ? '0 : count;

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> !refilling && count != '0);

    a_no_release_full: assert property (@(posedge clk) disable iff (!rst_n)
        release_vld |-> count != page_cnt_t'(`SW_NUM_PAGES));

endmodule

`default_nettype wire

// File: logic/packet_queues.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module packet_queues (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                push,
    input  wire packet_pkg::port_id_t                push_dest,
    input  wire buffer_pkg::desc_t                   push_desc,
    output logic [`SW_NUM_PORTS-1:0]                 not_empty,
    output buffer_pkg::desc_t [`SW_NUM_PORTS-1:0]    head_desc,
    input  wire logic                                pop,
    input  wire packet_pkg::port_id_t                pop_dest
);
    import buffer_pkg::*;

    localparam int ptr_w = $clog2(`SW_QUEUE_DEPTH);

    for (genvar q = 0; q < `SW_NUM_PORTS; q++) begin : g_queue
        desc_t            mem [`SW_QUEUE_DEPTH];
        logic [ptr_w-1:0] rd_ptr;
        logic [ptr_w-1:0] wr_ptr;
        logic [ptr_w:0]   count;
        logic             push_hit;
        logic             pop_hit;

        assign push_hit = push && push_dest == q;
        assign pop_hit  = pop && pop_dest == q;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push_hit) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop_hit) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + (ptr_w + 1)'(push_hit) - (ptr_w + 1)'(pop_hit);
            end
        end

        always_ff @(posedge clk) begin
            if (push_hit) begin
                mem[wr_ptr] <= push_desc;
            end
        end

        assign not_empty[q] = count != '0;
        assign head_desc[q] = mem[rd_ptr];

        a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
            push_hit |-> count != (ptr_w + 1)'(`SW_QUEUE_DEPTH));
    end

endmodule

`default_nettype wire

// File: logic/buffer_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module buffer_writer (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic [`SW_NUM_PORTS-1:0]                 pkt_avail,
    input  wire packet_pkg::port_id_t [`SW_NUM_PORTS-1:0] pkt_dest,
    input  wire packet_pkg::pkt_len_t [`SW_NUM_PORTS-1:0] pkt_len,
    output logic [`SW_NUM_PORTS-1:0]                      take,
    input  wire logic [`SW_NUM_PORTS-1:0]                 word_vld,
    input  wire packet_pkg::halfword_t [`SW_NUM_PORTS-1:0] word,
    output logic                                          alloc,
    input  wire buffer_pkg::page_ptr_t                    free_head,
    input  wire buffer_pkg::page_cnt_t                    free_count,
    output logic                                          data_wr_en,
    output buffer_pkg::data_addr_t                        data_wr_addr,
    output packet_pkg::halfword_t                         data_wr_data,
    output logic                                          link_wr_en,
    output buffer_pkg::page_ptr_t                         link_wr_addr,
    output buffer_pkg::page_ptr_t                         link_wr_data,
    output logic                                          push,
    output packet_pkg::port_id_t                          push_dest,
    output buffer_pkg::desc_t                             push_desc
);
    import packet_pkg::*;
    import buffer_pkg::*;

    logic [`SW_NUM_PORTS-1:0] eligible;
    port_id_t  rr_ptr;
    port_id_t  cand;
    port_id_t  sel;
    logic      found;
    logic      grant;
    logic      busy;
    logic      in_vld;
    logic      last_wr;
    port_id_t  cur_port;
    port_id_t  cur_dest;
    pkt_len_t  cur_len;
    pkt_len_t  got;
    word_idx_t idx;
    page_ptr_t cur_page;
    page_ptr_t first_page;

    function automatic pkt_len_t pages_for(input pkt_len_t len);
        return pkt_len_t'((len + `SW_PAGE_WORDS - 1) / `SW_PAGE_WORDS);
    endfunction

    // a buffer only competes when its whole packet fits
    always_comb begin
        for (int i = 0; i < `SW_NUM_PORTS; i++) begin
            eligible[i] = pkt_avail[i] && pkt_len_t'(free_count) >= pages_for(pkt_len[i]);
        end
    end

    // scan downwards so the port nearest the pointer wins
    always_comb begin
        found = 1'b0;
        sel   = rr_ptr;
        cand  = rr_ptr;
        for (int k = `SW_NUM_PORTS - 1; k >= 0; k--) begin
            cand = rr_ptr + port_id_t'(k);
            if (eligible[cand]) begin
                found = 1'b1;
                sel   = cand;
            end
        end
    end

    assign grant = !busy && found;

    always_comb begin
        take = '0;
        if (grant) begin
            take[sel] = 1'b1;
        end
    end

    assign in_vld = busy && word_vld[cur_port];
    // a fresh page is taken on every eighth word
    assign alloc  = in_vld && idx == '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            rr_ptr     <= '0;
            got        <= '0;
            idx        <= '0;
            data_wr_en <= 1'b0;
            link_wr_en <= 1'b0;
            last_wr    <= 1'b0;
            push       <= 1'b0;
        end else begin
            if (grant) begin
                busy   <= 1'b1;
                rr_ptr <= sel + 1'b1;
                got    <= '0;
                idx    <= '0;
            end else begin
                if (push) begin
                    busy <= 1'b0;
                end
                if (in_vld) begin
                    got <= got + 1'b1;
                    idx <= idx + 1'b1;
                end
            end
            data_wr_en <= in_vld;
            link_wr_en <= alloc && got != '0;
            last_wr    <= in_vld && got == cur_len - 1'b1;
            push       <= last_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            cur_port <= sel;
            cur_dest <= pkt_dest[sel];
            cur_len  <= pkt_len[sel];
        end
        if (alloc) begin
            cur_page <= free_head;
            if (got == '0) begin
                first_page <= free_head;
            end
        end
        data_wr_addr <= {alloc ? free_head : cur_page, idx};
        data_wr_data <= word[cur_port];
        // previous page points at the new one
        link_wr_addr <= cur_page;
        link_wr_data <= free_head;
    end

    assign push_dest = cur_dest;
    assign push_desc = '{first_page: first_page, len: cur_len};

endmodule

`default_nettype wire

// File: logic/buffer_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module buffer_reader (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic [`SW_NUM_PORTS-1:0]               not_empty,
    input  wire buffer_pkg::desc_t [`SW_NUM_PORTS-1:0]  head_desc,
    output logic                                        pop,
    output packet_pkg::port_id_t                        pop_dest,
    output buffer_pkg::data_addr_t                      data_rd_addr,
    output buffer_pkg::page_ptr_t                       link_rd_addr,
    input  wire packet_pkg::halfword_t                  data_rd_data,
    input  wire buffer_pkg::page_ptr_t                  link_rd_data,
    output logic                                        release_vld,
    output buffer_pkg::page_ptr_t                       release_page,
    output logic [`SW_NUM_PORTS-1:0]                    rd_sop,
    output logic [`SW_NUM_PORTS-1:0]                    rd_eop,
    output logic [`SW_NUM_PORTS-1:0]                    rd_vld,
    output packet_pkg::halfword_t [`SW_NUM_PORTS-1:0]   rd_data
);
    import packet_pkg::*;
    import buffer_pkg::*;

    port_id_t  rr_ptr;
    port_id_t  cand;
    port_id_t  sel;
    logic      active;
    logic      first;
    port_id_t  out_port;
    pkt_len_t  remain;
    word_idx_t idx;
    page_ptr_t page;
    logic      page_end;
    // one stage between read issue and output register
    logic      s1_vld;
    logic      s1_first;
    logic      s1_last;
    port_id_t  s1_port;

    always_comb begin
        sel  = rr_ptr;
        cand = rr_ptr;
        for (int k = `SW_NUM_PORTS - 1; k >= 0; k--) begin
            cand = rr_ptr + port_id_t'(k);
            if (not_empty[cand]) begin
                sel = cand;
            end
        end
    end

    assign pop      = !active && |not_empty;
    assign pop_dest = sel;

    assign data_rd_addr = {page, idx};
    // link of the current page is ready long before its last word
    assign link_rd_addr = page;
    assign page_end     = idx == word_idx_t'(`SW_PAGE_WORDS - 1) || remain == pkt_len_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr      <= '0;
            active      <= 1'b0;
            s1_vld      <= 1'b0;
            release_vld <= 1'b0;
            rd_sop      <= '0;
            rd_eop      <= '0;
            rd_vld      <= '0;
        end else begin
            if (pop) begin
                active <= 1'b1;
                rr_ptr <= sel + 1'b1;
            end else if (active && remain == pkt_len_t'(1)) begin
                active <= 1'b0;
            end
            s1_vld      <= active;
            release_vld <= active && page_end;
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                rd_vld[p] <= s1_vld && s1_port == port_id_t'(p);
                rd_sop[p] <= s1_vld && s1_first && s1_port == port_id_t'(p);
                rd_eop[p] <= s1_vld && s1_last && s1_port == port_id_t'(p);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            page     <= head_desc[sel].first_page;
            remain   <= head_desc[sel].len;
            idx      <= '0;
            first    <= 1'b1;
            out_port <= sel;
        end else if (active) begin
            remain <= remain - 1'b1;
            idx    <= idx + 1'b1;
            first  <= 1'b0;
            if (idx == word_idx_t'(`SW_PAGE_WORDS - 1)) begin
                page <= link_rd_data;
            end
        end
        s1_first     <= first;
        s1_last      <= remain == pkt_len_t'(1);
        s1_port      <= out_port;
        release_page <= page;
        if (s1_vld) begin
            rd_data[s1_port] <= data_rd_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/switch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module switch_top (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire logic [`SW_NUM_PORTS-1:0]                  wr_sop,
    input  wire logic [`SW_NUM_PORTS-1:0]                  wr_eop,
    input  wire logic [`SW_NUM_PORTS-1:0]                  wr_vld,
    input  wire packet_pkg::halfword_t [`SW_NUM_PORTS-1:0] wr_data,
    output logic [`SW_NUM_PORTS-1:0]                       full,
    output logic [`SW_NUM_PORTS-1:0]                       rd_sop,
    output logic [`SW_NUM_PORTS-1:0]                       rd_eop,
    output logic [`SW_NUM_PORTS-1:0]                       rd_vld,
    output packet_pkg::halfword_t [`SW_NUM_PORTS-1:0]      rd_data
);
    import packet_pkg::*;
    import buffer_pkg::*;

    logic [`SW_NUM_PORTS-1:0]      pkt_avail;
    port_id_t [`SW_NUM_PORTS-1:0]  pkt_dest;
    pkt_len_t [`SW_NUM_PORTS-1:0]  pkt_len;
    logic [`SW_NUM_PORTS-1:0]      take;
    logic [`SW_NUM_PORTS-1:0]      word_vld;
    halfword_t [`SW_NUM_PORTS-1:0] word;

    logic       alloc;
    page_ptr_t  free_head;
    page_cnt_t  free_count;
    logic       release_vld;
    page_ptr_t  release_page;

    logic       data_wr_en;
    data_addr_t data_wr_addr;
    halfword_t  data_wr_data;
    data_addr_t data_rd_addr;
    halfword_t  data_rd_data;
    logic       link_wr_en;
    page_ptr_t  link_wr_addr;
    page_ptr_t  link_wr_data;
    page_ptr_t  link_rd_addr;
    page_ptr_t  link_rd_data;

    logic                          push;
    port_id_t                      push_dest;
    desc_t                         push_desc;
    logic [`SW_NUM_PORTS-1:0]      not_empty;
    desc_t [`SW_NUM_PORTS-1:0]     head_desc;
    logic                          pop;
    port_id_t                      pop_dest;

    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_ingress
        ingress_buffer u_ingress (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_sop    (wr_sop[p]),
            .wr_eop    (wr_eop[p]),
            .wr_vld    (wr_vld[p]),
            .wr_data   (wr_data[p]),
            .full      (full[p]),
            .pkt_avail (pkt_avail[p]),
            .pkt_dest  (pkt_dest[p]),
            .pkt_len   (pkt_len[p]),
            .take      (take[p]),
            .word_vld  (word_vld[p]),
            .word      (word[p])
        );
    end

    buffer_writer u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt_avail    (pkt_avail),
        .pkt_dest     (pkt_dest),
        .pkt_len      (pkt_len),
        .take         (take),
        .word_vld     (word_vld),
        .word         (word),
        .alloc        (alloc),
        .free_head    (free_head),
        .free_count   (free_count),
        .data_wr_en   (data_wr_en),
        .data_wr_addr (data_wr_addr),
        .data_wr_data (data_wr_data),
        .link_wr_en   (link_wr_en),
        .link_wr_addr (link_wr_addr),
        .link_wr_data (link_wr_data),
        .push         (push),
        .push_dest    (push_dest),
        .push_desc    (push_desc)
    );

    free_page_list u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .free_head    (free_head),
        .release_vld  (release_vld),
        .release_page (release_page),
        .free_count   (free_count)
    );

    // halfword data, one page per 8 consecutive addresses
    page_store #(
        .word_t     (halfword_t),
        .addr_width ($bits(data_addr_t))
    ) u_data_store (
        .clk     (clk),
        .wr_en   (data_wr_en),
        .wr_addr (data_wr_addr),
        .wr_data (data_wr_data),
        .rd_addr (data_rd_addr),
        .rd_data (data_rd_data)
    );

    // jump table, next page of each packet page
    page_store #(
        .word_t     (page_ptr_t),
        .addr_width ($bits(page_ptr_t))
    ) u_link_store (
        .clk     (clk),
        .wr_en   (link_wr_en),
        .wr_addr (link_wr_addr),
        .wr_data (link_wr_data),
        .rd_addr (link_rd_addr),
        .rd_data (link_rd_data)
    );

    packet_queues u_queues (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_dest (push_dest),
        .push_desc (push_desc),
        .not_empty (not_empty),
        .head_desc (head_desc),
        .pop       (pop),
        .pop_dest  (pop_dest)
    );

    buffer_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .not_empty    (not_empty),
        .head_desc    (head_desc),
        .pop          (pop),
        .pop_dest     (pop_dest),
        .data_rd_addr (data_rd_addr),
        .link_rd_addr (link_rd_addr),
        .data_rd_data (data_rd_data),
        .link_rd_data (link_rd_data),
        .release_vld  (release_vld),
        .release_page (release_page),
        .rd_sop       (rd_sop),
        .rd_eop       (rd_eop),
        .rd_vld       (rd_vld),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

// File: tests/switch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "switch_defines.svh"

module switch_tb;
    import packet_pkg::*;

    localparam int num_rows   = 18;
    localparam int num_ports  = `SW_NUM_PORTS;
    localparam int clk_half   = 2;
    localparam int drive_skew = 1;

    logic                        clk;
    logic                        rst_n;
    logic [num_ports-1:0]        wr_sop;
    logic [num_ports-1:0]        wr_eop;
    logic [num_ports-1:0]        wr_vld;
    halfword_t [num_ports-1:0]   wr_data;
    logic [num_ports-1:0]        full;
    logic [num_ports-1:0]        rd_sop;
    logic [num_ports-1:0]        rd_eop;
    logic [num_ports-1:0]        rd_vld;
    halfword_t [num_ports-1:0]   rd_data;

    // source, destination, length, idle cycles before the packet
    int stim [num_rows][4] = '{
        '{0, 1,  2, 4},
        '{1, 2, 32, 3},
        '{0, 3,  9, 0},
        '{1, 3, 16, 0},
        '{2, 3,  5, 0},
        '{3, 3, 24, 0},
        '{0, 3, 32, 0},
        '{1, 3,  7, 0},
        '{2, 3, 31, 0},
        '{3, 3, 12, 0},
        '{2, 0, 32, 6},
        '{3, 1, 30, 0},
        '{0, 2, 17, 2},
        '{1, 0,  8, 0},
        '{2, 2, 25, 1},
        '{3, 3,  3, 0},
        '{0, 0, 32, 5},
        '{1, 1, 20, 0}
    };

    halfword_t exp_words [num_rows][`SW_MAX_PKT_WORDS];
    // row numbers in flight, one queue per source and destination pair
    int        exp_q [num_ports*num_ports][$];

    halfword_t got_words [num_ports][`SW_MAX_PKT_WORDS];
    int        got_cnt [num_ports];
    logic      collecting [num_ports];
    logic      taken [num_ports];
    logic      full_prev [num_ports];

    logic [31:0] lfsr;
    int          errors;
    int          passed;
    int          failed;
    int          done_cnt;
    int          cycles;
    int          limit;

    switch_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic halfword_t rand_halfword();
        halfword_t h;
        h = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_step(lfsr);
            h    = {h[14:0], lfsr[0]};
        end
        return h;
    endfunction

    task automatic check_idle(input string when_txt);
        if (full !== '0) begin
            $display("mismatch at %0t: full %s expected 0000 got %b", $time, when_txt, full);
            errors++;
        end
        if (rd_sop !== '0) begin
            $display("mismatch at %0t: rd_sop %s expected 0000 got %b", $time, when_txt, rd_sop);
            errors++;
        end
        if (rd_eop !== '0) begin
            $display("mismatch at %0t: rd_eop %s expected 0000 got %b", $time, when_txt, rd_eop);
            errors++;
        end
        if (rd_vld !== '0) begin
            $display("mismatch at %0t: rd_vld %s expected 0000 got %b", $time, when_txt, rd_vld);
            errors++;
        end
    endtask

    task automatic send_packet(input int row);
        int src;
        int dest;
        int len;
        src  = stim[row][0];
        dest = stim[row][1];
        len  = stim[row][2];
        repeat (stim[row][3]) begin
            @(posedge clk);
            #drive_skew;
        end
        while (full[src]) begin
            @(posedge clk);
            #drive_skew;
        end
        // header carries the source in bits 3..2 so the monitor can find its queue
        exp_words[row][0] = {pkt_len_t'(len), 3'b000, port_id_t'(src), port_id_t'(dest)};
        for (int i = 1; i < len; i++) begin
            exp_words[row][i] = rand_halfword();
        end
        exp_q[src*num_ports+dest].push_back(row);
        for (int i = 0; i < len; i++) begin
            wr_vld[src]  = 1'b1;
            wr_sop[src]  = (i == 0);
            wr_eop[src]  = (i == len - 1);
            wr_data[src] = exp_words[row][i];
            @(posedge clk);
            #drive_skew;
        end
        wr_vld[src]  = 1'b0;
        wr_sop[src]  = 1'b0;
        wr_eop[src]  = 1'b0;
        wr_data[src] = '0;
        if (!full[src]) begin
            $display("full on port %0d not high one cycle after wr_eop at %0t", src, $time);
            errors++;
        end
    endtask

    task automatic check_packet(input int p);
        int  src;
        int  q;
        int  row;
        int  len;
        bit  ok;
        ok  = 1'b1;
        src = int'(got_words[p][0][3:2]);
        q   = src * num_ports + p;
        done_cnt++;
        if (exp_q[q].size() == 0) begin
            $display("unexpected packet from source %0d on port %0d at %0t", src, p, $time);
            errors++;
            return;
        end
        row = exp_q[q].pop_front();
        len = stim[row][2];
        if (got_cnt[p] != len) begin
            $display("mismatch at %0t: rd_vld[%0d] cycles expected %0d got %0d",
                     $time, p, len, got_cnt[p]);
            errors++;
            ok = 1'b0;
        end else begin
            for (int i = 0; i < len; i++) begin
                if (ok && got_words[p][i] !== exp_words[row][i]) begin
                    $display("mismatch at %0t: rd_data[%0d] word %0d expected %h got %h",
                             $time, p, i, exp_words[row][i], got_words[p][i]);
                    errors++;
                    ok = 1'b0;
                end
            end
        end
        if (ok) begin
            passed++;
            $display("row %0d: port %0d to port %0d, %0d halfwords, ok", row, src, p, len);
        end else begin
            failed++;
            $display("row %0d: port %0d to port %0d, %0d halfwords, FAILED", row, src, p, len);
        end
    endtask

    // output monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                if (rd_sop[p]) begin
                    if (collecting[p]) begin
                        $display("rd_sop on port %0d before rd_eop at %0t", p, $time);
                        errors++;
                        done_cnt++;
                    end
                    collecting[p] = 1'b1;
                    got_cnt[p]    = 0;
                end
                if (collecting[p]) begin
                    if (!rd_vld[p]) begin
                        $display("rd_vld on port %0d dropped inside a packet at %0t", p, $time);
                        errors++;
                        done_cnt++;
                        collecting[p] = 1'b0;
                    end else begin
                        if (got_cnt[p] < `SW_MAX_PKT_WORDS) begin
                            got_words[p][got_cnt[p]] = rd_data[p];
                        end
                        got_cnt[p]++;
                        if (rd_eop[p]) begin
                            check_packet(p);
                            collecting[p] = 1'b0;
                        end
                    end
                end else if (rd_vld[p] || rd_eop[p]) begin
                    $display("rd_vld or rd_eop on port %0d outside a packet at %0t", p, $time);
                    errors++;
                end
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                collecting[p] = 1'b0;
            end
        end
    end

    // full may only fall once the writer has taken the packet
    always @(negedge clk) begin
        for (int p = 0; p < num_ports; p++) begin
            if (!rst_n) begin
                taken[p]     = 1'b0;
                full_prev[p] = 1'b0;
            end else begin
                if (UUT.take[p]) begin
                    taken[p] = 1'b1;
                end
                if (full_prev[p] && !full[p] && !taken[p]) begin
                    $display("full on port %0d fell before its packet was taken at %0t",
                             p, $time);
                    errors++;
                end
                if (!full[p]) begin
                    taken[p] = 1'b0;
                end
                full_prev[p] = full[p];
            end
        end
    end

    initial begin
        cycles = 0;
        limit  = 100;
        for (int r = 0; r < num_rows; r++) begin
            limit += stim[r][2] + stim[r][3] + 40;
        end
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d packets received",
                 cycles, done_cnt, num_rows);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int err_before;
        rst_n    = 1'b0;
        wr_sop   = '0;
        wr_eop   = '0;
        wr_vld   = '0;
        wr_data  = '0;
        errors   = 0;
        passed   = 0;
        failed   = 0;
        done_cnt = 0;
        lfsr     = 32'hb377512f;

        err_before = errors;
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #drive_skew;
            check_idle("during reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #drive_skew;
        check_idle("after reset");
        if (errors == err_before) begin
            passed++;
            $display("reset: outputs idle, ok");
        end else begin
            failed++;
            $display("reset: outputs idle, FAILED");
        end

        for (int r = 0; r < num_rows; r++) begin
            send_packet(r);
        end
        while (done_cnt < num_rows) begin
            @(posedge clk);
            #drive_skew;
        end
        // a few more cycles to catch any stray output
        repeat (20) @(posedge clk);

        for (int q = 0; q < num_ports * num_ports; q++) begin
            while (exp_q[q].size() > 0) begin
                $display("row %0d: never delivered, FAILED", exp_q[q].pop_front());
                failed++;
            end
        end
        $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/packet_pkg.sv
logic/buffer_pkg.sv
logic/ingress_buffer.sv
logic/page_store.sv
logic/free_page_list.sv
logic/packet_queues.sv
logic/buffer_writer.sv
logic/buffer_reader.sv
logic/switch_top.sv
tests/switch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= switch_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
